/* design/wimax_bist_pkg.sv */
/* WiMAX BIST shared definitions
   Block sizes, golden stage vectors, LED field map and run states */

package wimax_bist_pkg;

    // ========================================
    // Sizes and counts
    // ========================================
    localparam int prbs_block_bits  = 96;      // Randomizer block
    localparam int fec_block_bits   = 192;     // FEC and interleaver block
    localparam int num_packets      = 5;       // Blocks per checker run
    localparam int debounce_default = 500_000; // Key filter length in cycles

    // ========================================
    // Golden vectors, MSB sent first
    // ========================================
    // Randomizer input block from the 802.16 example
    localparam logic [prbs_block_bits-1:0] golden_prbs_in = {
        32'h4529c479, 32'had0f5528, 32'had87b576
    };
    // Randomizer output
    localparam logic [prbs_block_bits-1:0] golden_prbs_out = {
        32'hd4baa112, 32'hf2749630, 32'h27d4889c
    };
    // Rate 1/2 encoded block
    localparam logic [fec_block_bits-1:0] golden_fec_out = {
        32'h29c219fd, 32'hd636a7c9,
        32'h6136fb59, 32'h2bc2d9ef,
        32'h35d546aa, 32'he5c277de
    };
    // After both permutation steps
    localparam logic [fec_block_bits-1:0] golden_interleaver_out = {
        32'h77fa4f17, 32'h4e3ee670,
        32'he8cd3f76, 32'h90c42cdb,
        32'hf9b7fb43, 32'h6cf19abd
    };

    // LED word layout
    localparam int led_pass_lsb = 0;    // Three pass bits
    localparam int led_done_lsb = 3;    // Three done bits
    localparam int led_en_bit   = 6;
    localparam int led_width    = 7;

    typedef enum logic [1:0] {run_idle, run_active, run_stopped} run_state_t;

endpackage

/* design/key_debouncer.sv */
/* Start key debouncer
   Filters the raw active-low key and emits one pulse per accepted press */

`timescale 1ns/1ps

module key_debouncer #(
    parameter int debounce_cycles = wimax_bist_pkg::debounce_default
) (
    input  logic clk_100,
    input  logic reset_N,
    input  logic start_key,     // Raw key, active low, bouncy
    output logic start_pulse    // One cycle wide
);

    localparam int cnt_w = $clog2(debounce_cycles + 1);
    localparam logic [cnt_w-1:0] cnt_max = cnt_w'(debounce_cycles);

    logic [cnt_w-1:0] diff_cnt;     // Cycles the key has differed
    logic             key_stable;   // Accepted key level
    logic             key_stable_q; // Previous accepted level

    // ========================================
    // Level filter
    // ========================================
    always_ff @(posedge clk_100 or negedge reset_N) begin
        if (!reset_N) begin
            diff_cnt   <= '0;
            key_stable <= 1'b1;     // Key released
        end else if (start_key != key_stable) begin
            if (diff_cnt < cnt_max) begin
                diff_cnt <= diff_cnt + 1'b1;
            end else begin
                key_stable <= start_key;   // Held long enough
                diff_cnt   <= '0;
            end
        end else begin
            diff_cnt <= '0;         // Glitch over, start again
        end
    end

    // ========================================
    // Press edge
    // ========================================
    always_ff @(posedge clk_100 or negedge reset_N) begin
        if (!reset_N) begin
            key_stable_q <= 1'b1;
            start_pulse  <= 1'b0;
        end else begin
            key_stable_q <= key_stable;
            start_pulse  <= key_stable_q & ~key_stable;  // High to low only
        end
    end

endmodule

/* design/bist_control.sv */
/* BIST run control
   Holds the run state and drives the load pulse and enable level */

`timescale 1ns/1ps

module bist_control (
    input  logic clk_100,
    input  logic reset_N,
    input  logic start_pulse,       // Debounced press
    input  logic continuous_mode,   // High keeps the chain running
    input  logic all_done,          // Every checker finished
    output logic load,              // One cycle after a press
    output logic en                 // Chain enable level
);

    import wimax_bist_pkg::*;

    run_state_t run_state;
    logic       stop_now;           // Single-shot run complete

    assign stop_now = all_done && !continuous_mode;

    always_ff @(posedge clk_100 or negedge reset_N) begin
        if (!reset_N) begin
            run_state <= run_idle;
            load      <= 1'b0;
            en        <= 1'b0;
        end else begin
            // Every press reloads the chain, whatever the state
            load <= start_pulse;

            case (run_state)
                run_idle: begin
                    en <= 1'b0;
                    if (start_pulse) begin
                        run_state <= run_active;
                    end
                end
                run_active: begin
                    en <= !stop_now;            // Rises one cycle after load
                    if (stop_now) begin
                        run_state <= run_stopped;
                    end
                end
                run_stopped: begin
                    en <= 1'b0;                 // Stays down until reset
                end
                default: begin
                    run_state <= run_idle;
                    en        <= 1'b0;
                end
            endcase
        end
    end

endmodule

/* design/golden_source.sv */
/* Golden source for the randomizer input
   Serializes the reference block MSB first and repeats it */

`timescale 1ns/1ps

module golden_source (
    input  logic clk_100,
    input  logic reset_N,
    input  logic en,
    input  logic src_ready,     // Chain can take a bit
    output logic src_data       // Current bit, no latency
);

    import wimax_bist_pkg::*;

    localparam int idx_w = $clog2(prbs_block_bits);
    localparam logic [idx_w-1:0] idx_top = idx_w'(prbs_block_bits - 1);

    logic [idx_w-1:0] bit_idx;  // Counts down from the MSB
    logic             advance;

    assign advance = en && src_ready;

    always_ff @(posedge clk_100 or negedge reset_N) begin
        if (!reset_N) begin
            bit_idx <= idx_top;
        end else if (advance) begin
            bit_idx <= (bit_idx == '0) ? idx_top : bit_idx - 1'b1;  // Wrap to MSB
        end
    end

    assign src_data = golden_prbs_in[bit_idx];

endmodule

/* design/block_checker.sv */
/* Serial stage checker
   Compares a tap stream against its golden block over a fixed packet count */

`timescale 1ns/1ps

module block_checker #(
    parameter int                    block_bits = wimax_bist_pkg::prbs_block_bits,
    parameter logic [block_bits-1:0] golden     = wimax_bist_pkg::golden_prbs_out
) (
    input  logic clk_100,
    input  logic reset_N,
    input  logic tap_data,      // Serial stage output
    input  logic tap_valid,
    output logic pass,          // Sticky, low after any bad block
    output logic done           // All packets seen
);

    import wimax_bist_pkg::*;

    localparam int idx_w = $clog2(block_bits);
    localparam int pkt_w = (num_packets > 1) ? $clog2(num_packets) : 1;
    localparam logic [idx_w-1:0] idx_top  = idx_w'(block_bits - 1);
    localparam logic [pkt_w-1:0] pkt_last = pkt_w'(num_packets - 1);

    logic [idx_w-1:0] bit_idx;  // Expected bit position, MSB first
    logic [pkt_w-1:0] pkt_cnt;  // Blocks already checked
    logic             blk_err;  // Earlier bit of this block was wrong
    logic             bit_miss; // Current bit is wrong
    logic             take;     // Bit consumed this cycle

    assign take     = tap_valid && !done;
    assign bit_miss = (tap_data != golden[bit_idx]);

    // ========================================
    // Bit compare and block bookkeeping
    // ========================================
    always_ff @(posedge clk_100 or negedge reset_N) begin
        if (!reset_N) begin
            bit_idx <= idx_top;
            pkt_cnt <= '0;
            blk_err <= 1'b0;
            pass    <= 1'b1;
            done    <= 1'b0;
        end else if (take) begin
            if (bit_idx == '0) begin
                // Last bit counts against this block too
                if (blk_err || bit_miss) begin
                    pass <= 1'b0;
                end
                if (pkt_cnt == pkt_last) begin
                    done <= 1'b1;               // Ignore the tap from now on
                end else begin
                    pkt_cnt <= pkt_cnt + 1'b1;
                end
                bit_idx <= idx_top;
                blk_err <= 1'b0;                // Fresh block
            end else begin
                bit_idx <= bit_idx - 1'b1;
                if (bit_miss) begin
                    blk_err <= 1'b1;
                end
            end
        end
    end

endmodule

/* design/wimax_bist_top.sv */
/* WiMAX transmitter BIST harness
   Feeds the chain, checks three stage taps and reports on a status LED word */

`timescale 1ns/1ps

module wimax_bist_top #(
    parameter int debounce_cycles = wimax_bist_pkg::debounce_default
) (
    input  logic                               clk_100,
    input  logic                               reset_N,
    input  logic                               start_key,       // Active low
    input  logic                               continuous_mode,
    output logic                               load,
    output logic                               en,
    // Chain input
    output logic                               src_data,
    output logic                               src_valid,
    input  logic                               src_ready,
    // Stage taps
    input  logic                               prbs_data,
    input  logic                               prbs_valid,
    input  logic                               fec_data,
    input  logic                               fec_valid,
    input  logic                               inter_data,
    input  logic                               inter_valid,
    output logic [wimax_bist_pkg::led_width-1:0] status_leds
);

    import wimax_bist_pkg::*;

    logic start_pulse;
    logic all_done;
    logic prbs_pass, prbs_done;
    logic fec_pass, fec_done;
    logic inter_pass, inter_done;

    // ========================================
    // Key and run control
    // ========================================
    key_debouncer #(.debounce_cycles(debounce_cycles)) key_debouncer_inst (
        .clk_100(clk_100), .reset_N(reset_N),
        .start_key(start_key), .start_pulse(start_pulse)
    );

    assign all_done = prbs_done && fec_done && inter_done;

    bist_control bist_control_inst (
        .clk_100(clk_100), .reset_N(reset_N),
        .start_pulse(start_pulse), .continuous_mode(continuous_mode),
        .all_done(all_done), .load(load), .en(en)
    );

    // ========================================
    // Source and stage checkers
    // ========================================
    golden_source golden_source_inst (
        .clk_100(clk_100), .reset_N(reset_N),
        .en(en), .src_ready(src_ready), .src_data(src_data)
    );

    assign src_valid = en;      // Source always has a bit

    block_checker #(.block_bits(prbs_block_bits), .golden(golden_prbs_out)) prbs_checker (
        .clk_100(clk_100), .reset_N(reset_N), .tap_data(prbs_data),
        .tap_valid(prbs_valid), .pass(prbs_pass), .done(prbs_done)
    );

    block_checker #(.block_bits(fec_block_bits), .golden(golden_fec_out)) fec_checker (
        .clk_100(clk_100), .reset_N(reset_N), .tap_data(fec_data),
        .tap_valid(fec_valid), .pass(fec_pass), .done(fec_done)
    );

    block_checker #(
        .block_bits(fec_block_bits),
        .golden(golden_interleaver_out)
    ) interleaver_checker (
        .clk_100(clk_100), .reset_N(reset_N), .tap_data(inter_data),
        .tap_valid(inter_valid), .pass(inter_pass), .done(inter_done)
    );

    // LED word, randomizer in the low bit of each field
    assign status_leds[led_pass_lsb +: 3] = {inter_pass, fec_pass, prbs_pass};
    assign status_leds[led_done_lsb +: 3] = {inter_done, fec_done, prbs_done};
    assign status_leds[led_en_bit]        = en;

endmodule

/* testbench/tb_wimax_bist.sv */
/* WiMAX BIST harness testbench
   Plays the transmitter chain with random gaps and bit flips, checks LEDs and source */

`timescale 1ns/1ps

module tb_wimax_bist;

    import wimax_bist_pkg::*;

    // ========================================
    // Run sizing
    // ========================================
    localparam int tb_debounce = 16;
    localparam int run_tail    = 1200;      // Cycles streamed after all done
    localparam int flip_runs   = 6;
    localparam int num_runs    = flip_runs + 2;
    // Reset, key phases, five 192-bit blocks at 3/4 valid, tail
    localparam int run_cycles     = 2700;
    localparam int timeout_cycles = 3 * num_runs * run_cycles;

    logic clk_100 = 1'b0;
    logic reset_N;
    logic start_key, continuous_mode, src_ready;
    logic prbs_data, prbs_valid, fec_data, fec_valid, inter_data, inter_valid;
    logic load, en, src_data, src_valid;
    logic [led_width-1:0] status_leds;

    logic [31:0] lfsr_state = 32'h4444ab13;
    int          error_cnt  = 0;
    int          check_cnt  = 0;
    int          cycle_cnt  = 0;
    int          load_seen;                 // Load pulses since reset
    logic [6:0]  src_idx;                   // Model index into golden_prbs_in
    logic [7:0]  tap_idx [3];               // Model index per tap
    int          tap_blk [3];               // Blocks sent per tap
    int          flip_tap, flip_blk;        // flip_tap 3 means clean
    logic [7:0]  flip_bit;
    logic        en_exp;                    // Model enable level
    logic        en_rise;                   // Load seen, en due next cycle
    logic        en_fall;                   // Single shot over, en stays low

    always #4 clk_100 = ~clk_100;           // 8 ns period

    wimax_bist_top #(.debounce_cycles(tb_debounce)) wimax_bist_top_inst (
        .clk_100(clk_100), .reset_N(reset_N), .start_key(start_key),
        .continuous_mode(continuous_mode), .load(load), .en(en),
        .src_data(src_data), .src_valid(src_valid), .src_ready(src_ready),
        .prbs_data(prbs_data), .prbs_valid(prbs_valid),
        .fec_data(fec_data), .fec_valid(fec_valid),
        .inter_data(inter_data), .inter_valid(inter_valid),
        .status_leds(status_leds)
    );

    // Hang guard
    always @(posedge clk_100) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("Timeout after %0d cycles, the checkers never finished", cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ========================================
    // Random bits and compare
    // ========================================
    function automatic logic rand_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};    // Taps 32, 22, 2, 1
        return lfsr_state[0];
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], rand_bit()};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // ========================================
    // Chain model
    // ========================================
    function automatic logic golden_bit(input int t, input logic [7:0] idx);
        case (t)
            0:       return golden_prbs_out[idx[6:0]];
            1:       return golden_fec_out[idx];
            default: return golden_interleaver_out[idx];
        endcase
    endfunction

    // One tap, MSB first, repeating block, random gaps
    task automatic drive_tap(input int t, output logic data, output logic valid);
        int top;
        top   = (t == 0) ? prbs_block_bits : fec_block_bits;
        valid = en && (rand_bit() | rand_bit());    // Chain idle while en low
        data  = 1'b0;
        if (valid) begin
            data = golden_bit(t, tap_idx[t]);
            if (t == flip_tap && tap_blk[t] == flip_blk && tap_idx[t] == flip_bit) begin
                data = ~data;                       // Injected error
            end
            if (tap_idx[t] == 8'd0) begin
                tap_idx[t] = 8'(top - 1);
                tap_blk[t]++;
            end else begin
                tap_idx[t] = tap_idx[t] - 8'd1;
            end
        end
    endtask

    // One clock of stimulus, all drives on the falling edge
    task automatic chain_cycle();
        logic [2:0] done_exp;
        @(negedge clk_100);
        if (load) begin
            load_seen++;
        end
        // Enable follows the load pulse and the last done flag by one cycle
        if (en_rise) begin
            en_exp = 1'b1;
        end
        if (en_fall) begin
            en_exp = 1'b0;
        end
        check_value("en", 32'(en), 32'(en_exp));
        check_value("src_valid", 32'(src_valid), 32'(en_exp));
        check_value("en_led", 32'(status_leds[led_en_bit]), 32'(en_exp));
        // Done once the model has sent every packet on that tap
        for (int t = 0; t < 3; t++) begin
            done_exp[t] = (tap_blk[t] >= num_packets);
        end
        check_value("done_leds", 32'(status_leds[led_done_lsb +: 3]), 32'(done_exp));
        en_rise = load;
        if (!continuous_mode && done_exp == 3'b111) begin
            en_fall = 1'b1;
        end
        src_ready = rand_bit() | rand_bit();
        if (en && src_ready) begin
            check_value("src_data", 32'(src_data), 32'(golden_prbs_in[src_idx]));
            src_idx = (src_idx == 7'd0) ? 7'(prbs_block_bits - 1) : src_idx - 7'd1;
        end
        drive_tap(0, prbs_data, prbs_valid);
        drive_tap(1, fec_data, fec_valid);
        drive_tap(2, inter_data, inter_valid);
    endtask

    task automatic apply_reset();
        reset_N         = 1'b0;
        start_key       = 1'b1;                 // Released
        continuous_mode = 1'b0;
        src_ready       = 1'b0;
        {prbs_data, prbs_valid, fec_data, fec_valid, inter_data, inter_valid} = '0;
        src_idx    = 7'(prbs_block_bits - 1);
        tap_idx[0] = 8'(prbs_block_bits - 1);
        tap_idx[1] = 8'(fec_block_bits - 1);
        tap_idx[2] = 8'(fec_block_bits - 1);
        tap_blk    = '{0, 0, 0};
        en_exp     = 1'b0;
        en_rise    = 1'b0;
        en_fall    = 1'b0;
        repeat (8) @(negedge clk_100);
        reset_N = 1'b1;
        @(negedge clk_100);
    endtask

    task automatic hold_key(input logic level, input int cycles);
        start_key = level;
        repeat (cycles) chain_cycle();
    endtask

    // ========================================
    // One BIST run from reset
    // ========================================
    task automatic run_bist(input logic cont, input int ftap, input int fblk,
                            input logic [7:0] fbit, input logic glitch);
        int         en_high;
        logic [2:0] pass_exp;
        apply_reset();
        flip_tap        = ftap;
        flip_blk        = fblk;
        flip_bit        = fbit;
        continuous_mode = cont;
        load_seen       = 0;
        en_high         = 0;
        check_value("status_leds", 32'(status_leds), 32'h07);  // Pass high, done low, en low
        check_value("load", 32'(load), 32'h0);
        if (glitch) begin
            hold_key(1'b0, tb_debounce - 6);    // Too short to count
            hold_key(1'b1, 30);
            check_value("load_pulses", load_seen, 0);
        end
        hold_key(1'b0, 40);
        hold_key(1'b1, 40);
        check_value("load_pulses", load_seen, 1);
        check_value("en", 32'(en), 32'h1);
        while (status_leds[led_done_lsb +: 3] != 3'b111) begin
            chain_cycle();
        end
        repeat (run_tail) begin
            chain_cycle();
            if (en) begin
                en_high++;
            end
        end
        // Single shot drops en right after all done
        check_value("en_high_cycles", en_high, cont ? run_tail : 0);
        pass_exp = 3'b111;
        if (ftap < 3 && fblk < num_packets) begin
            pass_exp[ftap] = 1'b0;
        end
        check_value("pass_leds", 32'(status_leds[led_pass_lsb +: 3]), 32'(pass_exp));
        check_value("done_leds", 32'(status_leds[led_done_lsb +: 3]), 32'h7);
        check_value("en_led", 32'(status_leds[led_en_bit]), 32'(cont));
    endtask

    initial begin
        int         ftap, fblk;
        logic [7:0] fbit;
        logic       cont;
        run_bist(1'b0, 3, 0, 8'd0, 1'b1);   // Clean single shot with key glitch
        for (int r = 0; r < flip_runs; r++) begin
            ftap = int'(rand_bits(2)) % 3;
            fblk = int'(rand_bits(3));      // Blocks 5 to 7 land after done
            fbit = 8'(int'(rand_bits(7)) % prbs_block_bits);
            cont = rand_bit();
            run_bist(cont, ftap, fblk, fbit, 1'b0);
        end
        run_bist(1'b1, 3, 0, 8'd0, 1'b0);   // Clean continuous
        $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
design/wimax_bist_pkg.sv
design/key_debouncer.sv
design/bist_control.sv
design/golden_source.sv
design/block_checker.sv
design/wimax_bist_top.sv
testbench/tb_wimax_bist.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the WiMAX BIST testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module tb_wimax_bist -f tb.f -o tb_wimax_bist
output=$(./obj_dir/tb_wimax_bist)
echo "$output"

if grep -q "TEST PASSED" <<< "$output"; then
    exit 0
else
    echo "Simulation did not pass"
    exit 1
fi
